// File: sources.f
hw/trig_csr_pkg.sv
hw/trig_core_pkg.sv
hw/trig_csr_ctrl.sv
hw/trig_exec_match.sv
hw/trig_lsu_match.sv
hw/trig_unit.sv
verif/tb_clkgen.sv
verif/trig_assertions.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the trigger unit testbench with Verilator, runs it and scans the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "build or run did not complete"; exit 1; }
exit 0

// File: verif/tb_top.sv
/* Random CSR writes, fetches and LSU accesses against a reference model.
   Inputs change on the falling edge and outputs are checked 1 ns later. */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  localparam int unsigned SEED          = 32'hec44da27;
  localparam int          NUM_CYCLES    = 4000;
  localparam int          RESET_TIMEOUT = 50;                       // Cycles
  localparam int          RUN_LIMIT_NS  = (NUM_CYCLES + 200) * 10;  // Watchdog

  logic       clk;
  logic       rst_n;
  csr_word_t  csr_wdata;
  logic       tselect_we;
  logic       tdata1_we;
  logic       tdata2_we;
  logic       debug_mode;
  fetch_req_t fetch;
  lsu_req_t   lsu;
  csr_word_t  tselect_rdata;
  csr_word_t  tdata1_rdata;
  csr_word_t  tdata2_rdata;
  logic       match_if;
  logic       match_ex;

  // Reference state and hit statistics
  tsel_t       sel_m;
  csr_word_t   tdata1_m [NUM_TRIGGERS];
  csr_word_t   tdata2_m [NUM_TRIGGERS];
  int unsigned alone_if [NUM_TRIGGERS];  // Cycles where only this slot hit on fetch
  int unsigned alone_ex [NUM_TRIGGERS];
  int unsigned suppressed;               // Hits masked by debug mode

  tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  trig_unit dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .csr_wdata_i     (csr_wdata),
    .tselect_we_i    (tselect_we),
    .tdata1_we_i     (tdata1_we),
    .tdata2_we_i     (tdata2_we),
    .fetch_i         (fetch),
    .lsu_i           (lsu),
    .debug_mode_i    (debug_mode),
    .tselect_rdata_o (tselect_rdata),
    .tdata1_rdata_o  (tdata1_rdata),
    .tdata2_rdata_o  (tdata2_rdata),
    .match_if_o      (match_if),
    .match_ex_o      (match_ex)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Type 6 keeps M, U, execute, store, load and a legal match code
  function automatic csr_word_t expect_tdata1(csr_word_t w);
    logic [3:0] code;
    code = w[10:7];
    if (w[31:28] != 4'd6) return 32'hF800_0000;
    if ((code != 4'd0) && (code != 4'd2) && (code != 4'd3)) code = 4'd0;
    return {4'd6, 1'b1, 11'd0, 4'd1, 1'b0, code, w[6], 2'b00, w[3], w[2:0]};
  endfunction

  function automatic logic priv_allowed(csr_word_t t1, privlvl_t p);
    return (t1[6] && (p == PRIV_LVL_M)) || (t1[3] && (p == PRIV_LVL_U));
  endfunction

  function automatic logic [NUM_TRIGGERS-1:0] fetch_slots(fetch_req_t f);
    logic [NUM_TRIGGERS-1:0] hit;
    logic                    cmp;
    hit = '0;
    for (int s = 0; s < NUM_TRIGGERS; s++) begin
      case (tdata1_m[s][10:7])
        4'd2:    cmp = (f.pc >= tdata2_m[s]);
        4'd3:    cmp = (f.pc < tdata2_m[s]);
        default: cmp = (f.pc == tdata2_m[s]);
      endcase
      hit[s] = (tdata1_m[s][31:28] == 4'd6) && tdata1_m[s][2] &&
               priv_allowed(tdata1_m[s], f.priv) && cmp;
    end
    return hit;  // Debug mode not applied here
  endfunction

  function automatic logic [NUM_TRIGGERS-1:0] lsu_slots(lsu_req_t r);
    logic [NUM_TRIGGERS-1:0] hit;
    logic [1:0]              hi;
    logic [1:0]              lo;
    logic                    cmp;
    logic                    dir;
    hit = '0;
    hi  = r.be[3] ? 2'd3 : r.be[2] ? 2'd2 : r.be[1] ? 2'd1 : 2'd0;
    lo  = r.be[0] ? 2'd0 : r.be[1] ? 2'd1 : r.be[2] ? 2'd2 : r.be[3] ? 2'd3 : 2'd0;
    for (int s = 0; s < NUM_TRIGGERS; s++) begin
      case (tdata1_m[s][10:7])
        4'd2:    cmp = ({r.addr[31:2], hi} >= tdata2_m[s]);
        4'd3:    cmp = ({r.addr[31:2], lo} < tdata2_m[s]);
        default: cmp = (r.addr[31:2] == tdata2_m[s][31:2]) && r.be[tdata2_m[s][1:0]];
      endcase
      dir    = r.we ? tdata1_m[s][1] : tdata1_m[s][0];
      hit[s] = r.valid && (tdata1_m[s][31:28] == 4'd6) && dir &&
               priv_allowed(tdata1_m[s], r.priv) && cmp;
    end
    return hit;
  endfunction

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  task automatic check_eq(input string name, input csr_word_t expected, input csr_word_t actual);
    if (expected !== actual) begin
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic drive_idle();
    csr_wdata  = '0;
    tselect_we = 1'b0;
    tdata1_we  = 1'b0;
    tdata2_we  = 1'b0;
    debug_mode = 1'b0;
    fetch      = '0;
    lsu        = '0;
  endtask

  // Mostly type 6 with a legal match code and sometimes anything
  function automatic csr_word_t shape_tdata1(csr_word_t w);
    csr_word_t r;
    r = w;
    if (($urandom % 4) != 0) r[31:28] = 4'd6;
    case ($urandom % 4)
      0:       r[10:7] = 4'd0;
      1:       r[10:7] = 4'd2;
      2:       r[10:7] = 4'd3;
      default: ;  // Random code kept, often illegal
    endcase
    return r;
  endfunction

  task automatic drive_random();
    int unsigned op;
    tsel_t       slot;
    drive_idle();
    op        = $urandom % 8;
    csr_wdata = $urandom;
    case (op)
      0: begin
        tselect_we = 1'b1;
        if (($urandom % 3) != 0) csr_wdata = $urandom % NUM_TRIGGERS;  // In range
      end
      1: begin
        tdata1_we = 1'b1;
        csr_wdata = shape_tdata1(csr_wdata);
      end
      2: tdata2_we = 1'b1;
      3: begin
        // All three strobes share one write word
        {tselect_we, tdata1_we, tdata2_we} = 3'b111;
        csr_wdata = shape_tdata1(csr_wdata);
      end
      default: ;
    endcase
    debug_mode = (($urandom % 8) == 0);
    slot       = tsel_t'($urandom);
    fetch.priv = (($urandom % 2) == 1) ? PRIV_LVL_M : PRIV_LVL_U;
    fetch.pc   = (($urandom % 4) == 0) ? csr_word_t'($urandom)
                                       : tdata2_m[slot] + csr_word_t'($urandom % 9) - 32'd4;
    slot       = tsel_t'($urandom);
    lsu.valid  = (($urandom % 4) != 0);
    lsu.we     = (($urandom % 2) == 1);
    lsu.be     = be_t'($urandom);
    lsu.priv   = (($urandom % 2) == 1) ? PRIV_LVL_M : PRIV_LVL_U;
    lsu.addr   = tdata2_m[slot] + csr_word_t'($urandom % 17) - 32'd8;  // Near the slot
  endtask

  task automatic check_outputs();
    logic [NUM_TRIGGERS-1:0] if_hits;
    logic [NUM_TRIGGERS-1:0] ex_hits;
    if_hits = fetch_slots(fetch);
    ex_hits = lsu_slots(lsu);
    check_eq("tselect_readback", csr_word_t'(sel_m), tselect_rdata);
    check_eq("tdata1_readback", tdata1_m[sel_m], tdata1_rdata);
    check_eq("tdata2_readback", tdata2_m[sel_m], tdata2_rdata);
    check_eq("match_if", 32'(!debug_mode && (|if_hits)), 32'(match_if));
    check_eq("match_ex", 32'(!debug_mode && (|ex_hits)), 32'(match_ex));
    if (debug_mode && ((|if_hits) || (|ex_hits))) suppressed++;
    for (int s = 0; s < NUM_TRIGGERS; s++) begin
      if (!debug_mode && if_hits[s] && ($countones(if_hits) == 1)) alone_if[s]++;
      if (!debug_mode && ex_hits[s] && ($countones(ex_hits) == 1)) alone_ex[s]++;
    end
  endtask

  // Writes land at the next rising edge and all use the old tselect
  task automatic update_model();
    tsel_t old_sel;
    old_sel = sel_m;
    if (tselect_we && (csr_wdata < NUM_TRIGGERS)) sel_m = tsel_t'(csr_wdata);
    if (tdata1_we) tdata1_m[old_sel] = expect_tdata1(csr_wdata);
    if (tdata2_we) tdata2_m[old_sel] = csr_wdata;
  endtask

  initial begin
    #(RUN_LIMIT_NS);
    $display("Watchdog expired before the run completed");
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    int  wait_cnt;
    logic covered;
    void'($urandom(SEED));
    drive_idle();
    sel_m      = '0;
    suppressed = 0;
    for (int s = 0; s < NUM_TRIGGERS; s++) begin
      tdata1_m[s] = 32'hF800_0000;  // Disabled with dmode set
      tdata2_m[s] = '0;
      alone_if[s] = 0;
      alone_ex[s] = 0;
    end

    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > RESET_TIMEOUT) begin
        $display("Reset was never released");
        $display("TESTBENCH FAILED");
        $fatal(1, "reset timeout");
      end
    end

    // Reset values
    @(negedge clk);
    #1;
    check_eq("reset_tselect", 32'd0, tselect_rdata);
    check_eq("reset_tdata1", 32'hF800_0000, tdata1_rdata);
    check_eq("reset_tdata2", 32'd0, tdata2_rdata);
    check_eq("reset_match_if", 32'd0, 32'(match_if));
    check_eq("reset_match_ex", 32'd0, 32'(match_ex));

    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clk);
      drive_random();
      #1;
      check_outputs();
      update_model();
    end

    covered = (suppressed > 0);
    for (int s = 0; s < NUM_TRIGGERS; s++) begin
      covered = covered && (alone_if[s] > 0) && (alone_ex[s] > 0);
    end
    if (!covered) begin
      $display("Some slot never matched alone, or debug mode never masked a hit");
      $display("TESTBENCH FAILED");
      $fatal(1, "stimulus did not reach every match case");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/trig_assertions.sv
/* Output invariants of trig_unit, bound into every instance.
   Sampled on the rising clock and held off while reset is low. */
`timescale 1ns/1ps
`default_nettype none

module trig_assertions (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    debug_mode_i,
  input logic                    match_if_i,
  input logic                    match_ex_i,
  input trig_csr_pkg::csr_word_t tselect_rdata_i,
  input trig_csr_pkg::csr_word_t tdata1_rdata_i
);
  import trig_csr_pkg::*;

  // Debug mode masks every slot
  a_no_match_in_debug : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_mode_i |-> (!match_if_i && !match_ex_i))
    else $error("match raised while debug_mode_i is high");

  a_tselect_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tselect_rdata_i < NUM_TRIGGERS)
    else $error("tselect readback is out of range");

  // Only mcontrol6 or disabled can ever be stored
  a_tdata1_type : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tdata1_rdata_i[TDATA1_TYPE_HI:TDATA1_TYPE_LO] == TTYPE_MCONTROL6) ||
    (tdata1_rdata_i[TDATA1_TYPE_HI:TDATA1_TYPE_LO] == TTYPE_DISABLED))
    else $error("tdata1 type is neither mcontrol6 nor disabled");

endmodule

bind trig_unit trig_assertions u_assertions (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .debug_mode_i    (debug_mode_i),
  .match_if_i      (match_if_o),
  .match_ex_i      (match_ex_o),
  .tselect_rdata_i (tselect_rdata_o),
  .tdata1_rdata_i  (tdata1_rdata_o)
);

`default_nettype wire

// File: verif/tb_clkgen.sv
/* Free running 10 ns clock for the testbench.
   Reset is held low for the first 3 cycles and released on a falling edge. */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the sampling edge
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: hw/trig_unit.sv
/* Debug trigger unit top, CSR block plus IF and EX matchers.
   No handshake. CSR writes are strobes, matches are same cycle levels. */
`timescale 1ns/1ps
`default_nettype none

module trig_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // CSR port
  input  trig_csr_pkg::csr_word_t  csr_wdata_i,
  input  logic                     tselect_we_i,
  input  logic                     tdata1_we_i,
  input  logic                     tdata2_we_i,
  // Core side
  input  trig_core_pkg::fetch_req_t fetch_i,
  input  trig_core_pkg::lsu_req_t   lsu_i,
  input  logic                     debug_mode_i,
  // Readback
  output trig_csr_pkg::csr_word_t  tselect_rdata_o,
  output trig_csr_pkg::csr_word_t  tdata1_rdata_o,
  output trig_csr_pkg::csr_word_t  tdata2_rdata_o,
  // Matches
  output logic                     match_if_o,  // Instruction address hit
  output logic                     match_ex_o   // Load/store address hit
);
  import trig_csr_pkg::*;

  trig_cfg_t [NUM_TRIGGERS-1:0] cfg;  // Decoded slots, shared by both matchers

  trig_csr_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_wdata_i     (csr_wdata_i),
    .tselect_we_i    (tselect_we_i),
    .tdata1_we_i     (tdata1_we_i),
    .tdata2_we_i     (tdata2_we_i),
    .debug_mode_i    (debug_mode_i),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .cfg_o           (cfg)
  );

  trig_exec_match u_exec (
    .fetch_i (fetch_i),
    .cfg_i   (cfg),
    .match_o (match_if_o)
  );

  trig_lsu_match u_lsu (
    .lsu_i   (lsu_i),
    .cfg_i   (cfg),
    .match_o (match_ex_o)
  );

endmodule

`default_nettype wire

// File: hw/trig_lsu_match.sv
/* Load/store address match on the EX stage access, byte granular via be.
   Split misaligned accesses are checked one part at a time. */
`timescale 1ns/1ps
`default_nettype none

module trig_lsu_match (
  input  trig_core_pkg::lsu_req_t                                  lsu_i,
  input  trig_csr_pkg::trig_cfg_t [trig_csr_pkg::NUM_TRIGGERS-1:0] cfg_i,
  output logic                                                     match_o
);
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  logic [1:0]              high_lsb;   // Highest enabled byte index
  logic [1:0]              low_lsb;    // Lowest enabled byte index
  addr_t                   addr_high;  // Highest byte touched
  addr_t                   addr_low;   // Lowest byte touched
  logic [NUM_TRIGGERS-1:0] dir_ok;
  logic [NUM_TRIGGERS-1:0] priv_ok;
  logic [NUM_TRIGGERS-1:0] byte_ok;    // Some enabled byte equals addr[1:0]
  logic [NUM_TRIGGERS-1:0] addr_ok;
  logic [NUM_TRIGGERS-1:0] slot_hit;

  //////////////////////////////
  // Byte span of the access
  //////////////////////////////
  always_comb begin
    high_lsb = 2'd0;  // Stays 0 with no enables
    low_lsb  = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_i.be[b]) begin
        high_lsb = 2'(b);  // Last set bit wins
      end
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_i.be[b]) begin
        low_lsb = 2'(b);   // First set bit wins
      end
    end
  end

  assign addr_high = {lsu_i.addr[31:2], high_lsb};
  assign addr_low  = {lsu_i.addr[31:2], low_lsb};

  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      dir_ok[i]  = (cfg_i[i].load && !lsu_i.we) || (cfg_i[i].store && lsu_i.we);
      priv_ok[i] = (cfg_i[i].m_en && (lsu_i.priv == PRIV_LVL_M)) ||
                   (cfg_i[i].u_en && (lsu_i.priv == PRIV_LVL_U));

      byte_ok[i] = 1'b0;
      for (int b = 0; b < 4; b++) begin
        if (lsu_i.be[b] && (2'(b) == cfg_i[i].addr[1:0])) begin
          byte_ok[i] = 1'b1;
        end
      end

      // GE fails only if no byte reaches addr, LT fails only if none is below
      case (cfg_i[i].mode)
        MATCH_EQ: addr_ok[i] = (lsu_i.addr[31:2] == cfg_i[i].addr[31:2]) && byte_ok[i];
        MATCH_GE: addr_ok[i] = (addr_high >= cfg_i[i].addr);
        MATCH_LT: addr_ok[i] = (addr_low  <  cfg_i[i].addr);
        default:  addr_ok[i] = 1'b0;
      endcase

      slot_hit[i] = lsu_i.valid && cfg_i[i].active && dir_ok[i] && priv_ok[i] && addr_ok[i];
    end
  end

  assign match_o = |slot_hit;

endmodule

`default_nettype wire

// File: hw/trig_exec_match.sv
/* Instruction address match on the IF stage PC.
   Purely combinational, cfg_i.active already carries the debug mode gate. */
`timescale 1ns/1ps
`default_nettype none

module trig_exec_match (
  input  trig_core_pkg::fetch_req_t                                fetch_i,
  input  trig_csr_pkg::trig_cfg_t [trig_csr_pkg::NUM_TRIGGERS-1:0] cfg_i,
  output logic                                                     match_o
);
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  logic [NUM_TRIGGERS-1:0] priv_ok;   // Privilege filter per slot
  logic [NUM_TRIGGERS-1:0] addr_ok;   // PC compare per slot
  logic [NUM_TRIGGERS-1:0] slot_hit;

  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      priv_ok[i] = (cfg_i[i].m_en && (fetch_i.priv == PRIV_LVL_M)) ||
                   (cfg_i[i].u_en && (fetch_i.priv == PRIV_LVL_U));

      case (cfg_i[i].mode)
        MATCH_EQ: addr_ok[i] = (fetch_i.pc == cfg_i[i].addr);
        MATCH_GE: addr_ok[i] = (fetch_i.pc >= cfg_i[i].addr);  // Unsigned
        MATCH_LT: addr_ok[i] = (fetch_i.pc <  cfg_i[i].addr);
        default:  addr_ok[i] = 1'b0;                           // Not reachable after WARL
      endcase

      slot_hit[i] = cfg_i[i].active && cfg_i[i].execute && priv_ok[i] && addr_ok[i];
    end
  end

  assign match_o = |slot_hit;  // Any slot fires

endmodule

`default_nettype wire

// File: hw/trig_csr_ctrl.sv
/* tselect, tdata1 and tdata2 for every slot, WARL resolved on write.
   All writes in a cycle use the tselect held before the edge. */
`timescale 1ns/1ps
`default_nettype none

module trig_csr_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  trig_csr_pkg::csr_word_t csr_wdata_i,
  input  logic                    tselect_we_i,  // One cycle strobes
  input  logic                    tdata1_we_i,
  input  logic                    tdata2_we_i,
  input  logic                    debug_mode_i,  // Suppresses every slot
  output trig_csr_pkg::csr_word_t tselect_rdata_o,
  output trig_csr_pkg::csr_word_t tdata1_rdata_o,
  output trig_csr_pkg::csr_word_t tdata2_rdata_o,
  output trig_csr_pkg::trig_cfg_t [trig_csr_pkg::NUM_TRIGGERS-1:0] cfg_o
);
  import trig_csr_pkg::*;

  tsel_t                   tselect_q;
  tsel_t                   tselect_n;
  csr_word_t               tdata1_n;               // Resolved tdata1 write value
  csr_word_t               tdata1_q [NUM_TRIGGERS];
  csr_word_t               tdata2_q [NUM_TRIGGERS];
  logic [NUM_TRIGGERS-1:0] tdata1_we_slot;         // Write enables decoded by slot
  logic [NUM_TRIGGERS-1:0] tdata2_we_slot;

  // mcontrol6 WARL, anything but type 6 becomes a disabled trigger
  function automatic csr_word_t resolve_tdata1(csr_word_t wdata);
    csr_word_t   res;
    match_mode_t mode;
    res  = '0;
    mode = match_mode_t'(wdata[TDATA1_MATCH_HI:TDATA1_MATCH_LO]);
    if (ttype_t'(wdata[TDATA1_TYPE_HI:TDATA1_TYPE_LO]) != TTYPE_MCONTROL6) begin
      res = TDATA1_RST_VAL;
    end else begin
      res[TDATA1_TYPE_HI:TDATA1_TYPE_LO]     = TTYPE_MCONTROL6;
      res[TDATA1_DMODE]                      = 1'b1;          // Debug mode access only
      res[TDATA1_ACTION_HI:TDATA1_ACTION_LO] = ACTION_DEBUG;  // Action is WARL 1
      // Unsupported match codes fall back to equal
      if ((mode == MATCH_EQ) || (mode == MATCH_GE) || (mode == MATCH_LT)) begin
        res[TDATA1_MATCH_HI:TDATA1_MATCH_LO] = mode;
      end else begin
        res[TDATA1_MATCH_HI:TDATA1_MATCH_LO] = MATCH_EQ;
      end
      res[TDATA1_M]       = wdata[TDATA1_M];
      res[TDATA1_U]       = wdata[TDATA1_U];
      res[TDATA1_EXECUTE] = wdata[TDATA1_EXECUTE];
      res[TDATA1_STORE]   = wdata[TDATA1_STORE];
      res[TDATA1_LOAD]    = wdata[TDATA1_LOAD];
    end
    return res;
  endfunction

  //////////////////////////////
  // tselect
  //////////////////////////////

  // Out of range writes keep the old slot
  assign tselect_n = (csr_wdata_i < NUM_TRIGGERS) ? tsel_t'(csr_wdata_i) : tselect_q;
  assign tdata1_n  = resolve_tdata1(csr_wdata_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i) begin
      tselect_q <= tselect_n;
    end
  end

  //////////////////////////////
  // Per slot tdata registers
  //////////////////////////////
  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : g_slot
    // Old tselect decides the target slot
    assign tdata1_we_slot[i] = tdata1_we_i && (tselect_q == tsel_t'(i));
    assign tdata2_we_slot[i] = tdata2_we_i && (tselect_q == tsel_t'(i));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        tdata1_q[i] <= TDATA1_RST_VAL;
        tdata2_q[i] <= '0;
      end else begin
        if (tdata1_we_slot[i]) begin
          tdata1_q[i] <= tdata1_n;
        end
        if (tdata2_we_slot[i]) begin
          tdata2_q[i] <= csr_wdata_i;  // Any value legal for type 6 and 15
        end
      end
    end

    // Decode the slot for the matchers
    always_comb begin
      cfg_o[i].active  = (ttype_t'(tdata1_q[i][TDATA1_TYPE_HI:TDATA1_TYPE_LO]) == TTYPE_MCONTROL6)
                         && !debug_mode_i;
      cfg_o[i].execute = tdata1_q[i][TDATA1_EXECUTE];
      cfg_o[i].load    = tdata1_q[i][TDATA1_LOAD];
      cfg_o[i].store   = tdata1_q[i][TDATA1_STORE];
      cfg_o[i].m_en    = tdata1_q[i][TDATA1_M];
      cfg_o[i].u_en    = tdata1_q[i][TDATA1_U];
      cfg_o[i].mode    = match_mode_t'(tdata1_q[i][TDATA1_MATCH_HI:TDATA1_MATCH_LO]);
      cfg_o[i].addr    = tdata2_q[i];
    end
  end

  // Readback of the selected slot, tselect is always in range
  assign tselect_rdata_o = csr_word_t'(tselect_q);
  assign tdata1_rdata_o  = tdata1_q[tselect_q];
  assign tdata2_rdata_o  = tdata2_q[tselect_q];

endmodule

`default_nettype wire

// File: hw/trig_core_pkg.sv
/* Core side request types seen by the trigger matchers.
   Only M and U privilege levels exist on this core. */
`default_nettype none

package trig_core_pkg;

  typedef logic [31:0] addr_t;  // Byte address on fetch and LSU
  typedef logic [3:0]  be_t;    // LSU byte enables within a word

  // Privilege level encoding, S mode is absent
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  // IF stage view
  typedef struct packed {
    addr_t    pc;    // Fetch PC
    privlvl_t priv;  // Privilege of the fetch
  } fetch_req_t;

  // EX stage LSU view
  typedef struct packed {
    logic     valid;  // Access present this cycle
    logic     we;     // 1 store, 0 load
    be_t      be;
    addr_t    addr;   // Word address plus offset
    privlvl_t priv;
  } lsu_req_t;

endpackage

`default_nettype wire

// File: hw/trig_csr_pkg.sv
/* Trigger CSR layout for a two slot mcontrol6 unit.
   Only type 6 and type 15 are legal, every other type resolves to disabled. */
`default_nettype none

package trig_csr_pkg;

  localparam int unsigned NUM_TRIGGERS = 2;  // Trigger slots behind tselect

  typedef logic [31:0]                       csr_word_t;    // Raw CSR data word
  typedef logic [$clog2(NUM_TRIGGERS)-1:0]   tsel_t;        // Slot index
  typedef logic [3:0]                        ttype_t;       // tdata1.type
  typedef logic [3:0]                        match_mode_t;  // mcontrol6.match

  // Trigger type codes
  localparam ttype_t TTYPE_MCONTROL6 = 4'd6;
  localparam ttype_t TTYPE_DISABLED  = 4'd15;

  // Match codes, WARL to these three
  localparam match_mode_t MATCH_EQ = 4'd0;  // Equal
  localparam match_mode_t MATCH_GE = 4'd2;  // Unsigned greater or equal
  localparam match_mode_t MATCH_LT = 4'd3;  // Unsigned less than

  localparam logic [3:0] ACTION_DEBUG = 4'd1;  // Enter debug mode on hit

  //////////////////////////////
  // tdata1 field positions
  //////////////////////////////
  localparam int TDATA1_TYPE_HI   = 31;
  localparam int TDATA1_TYPE_LO   = 28;
  localparam int TDATA1_DMODE     = 27;  // Debug mode only access
  localparam int TDATA1_ACTION_HI = 15;
  localparam int TDATA1_ACTION_LO = 12;
  localparam int TDATA1_MATCH_HI  = 10;
  localparam int TDATA1_MATCH_LO  = 7;
  localparam int TDATA1_M         = 6;
  localparam int TDATA1_U         = 3;
  localparam int TDATA1_EXECUTE   = 2;
  localparam int TDATA1_STORE     = 1;
  localparam int TDATA1_LOAD      = 0;

  // Disabled trigger with dmode set, 0xF8000000
  localparam csr_word_t TDATA1_RST_VAL = {TTYPE_DISABLED, 1'b1, 27'd0};

  // Decoded view of one slot, as seen by the matchers
  typedef struct packed {
    logic        active;   // mcontrol6 and core not in debug mode
    logic        execute;  // Instruction address match enabled
    logic        load;
    logic        store;
    logic        m_en;     // Match in M mode
    logic        u_en;     // Match in U mode
    match_mode_t mode;
    csr_word_t   addr;     // tdata2
  } trig_cfg_t;

endpackage

`default_nettype wire
